//--- Bender.yml
package:
  name: twiddle_pfa

sources:
  - files:
      - design/twiddle_pkg.sv
      - design/stage_ctrl_if.sv
      - design/burst_seq_fsm.sv
      - design/twiddle_exp_counter.sv
      - design/twiddle_rom.sv
      - design/cmul_lane.sv
      - design/twiddle_pfa.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/twiddle_tb.sv

//--- design/burst_seq_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module burst_seq_fsm
(
	input logic clk,
	input logic rst_n,
	input logic in_val,
	input twiddle_pkg::radix_t factor,
	input logic [7:0] addr_step,
	input logic [7:0] exp_ceil,
	input logic [7:0] exp_time,
	output twiddle_pkg::radix_t radix,
	stage_ctrl_if.seq ctrl
);

	import twiddle_pkg::*;

	localparam logic IDLE = 1'b0;
	localparam logic RUN = 1'b1;

	logic state;
	logic state_next;

	radix_t radix_q;
	logic [7:0] step_q;
	logic [7:0] ceil_q;
	logic [7:0] time_q;

	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:
				if (in_val)
					state_next = RUN;
			RUN:
				if (!in_val)
					state_next = IDLE;
			default:
				state_next = IDLE;
		endcase
	end

	// Configuration is sampled only in idle cycles, so a burst sees the values
	// that were present on the cycle before it started.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			radix_q <= R_16;
			step_q <= 8'd0;
			ceil_q <= 8'd1;
			time_q <= 8'd1;
		end
		else
		begin
			state <= state_next;
			if (state_next == IDLE)
			begin
				radix_q <= factor;
				step_q <= addr_step;
				ceil_q <= exp_ceil;
				time_q <= exp_time;
			end
		end
	end

	assign ctrl.run = (state_next == RUN);
	assign ctrl.addr_step = step_q;
	assign ctrl.exp_ceil = ceil_q;
	assign ctrl.exp_time = time_q;
	assign radix = radix_q;

	// A zero ceiling or period would leave the exponent counter without a wrap point.
	a_cfg_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl.run |-> (ctrl.exp_ceil != 8'd0) && (ctrl.exp_time != 8'd0));

endmodule

`default_nettype wire

//--- design/cmul_lane.sv
`timescale 1ns/1ps
`default_nettype none

module cmul_lane
#(
	parameter int w_data = twiddle_pkg::W_DATA
)
(
	input logic clk,
	input logic rst_n,
	input logic val_d,
	input logic signed [w_data-1:0] din_real,
	input logic signed [w_data-1:0] din_imag,
	input logic signed [twiddle_pkg::W_TW-1:0] tw_real,
	input logic signed [twiddle_pkg::W_TW-1:0] tw_imag,
	output logic signed [w_data-1:0] dout_real,
	output logic signed [w_data-1:0] dout_imag
);

	import twiddle_pkg::*;

	logic signed [w_data-1:0] din_re_q;
	logic signed [w_data-1:0] din_im_q;
	logic signed [W_PROD-1:0] prod_re;
	logic signed [W_PROD-1:0] prod_im;

	// Data waits one cycle here so that it meets the twiddle read from the ROM.
	always_ff @(posedge clk)
	begin
		din_re_q <= din_real;
		din_im_q <= din_imag;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			prod_re <= '0;
			prod_im <= '0;
		end
		else if (val_d)
		begin
			prod_re <= din_re_q * tw_real - din_im_q * tw_imag;
			prod_im <= din_re_q * tw_imag + din_im_q * tw_real;
		end
		else
		begin
			prod_re <= '0;
			prod_im <= '0;
		end
	end

	// Twiddles carry FRAC fraction bits, which the slice drops again.
	assign dout_real = prod_re[w_data+FRAC-1:FRAC];
	assign dout_imag = prod_im[w_data+FRAC-1:FRAC];

endmodule

`default_nettype wire

//--- design/stage_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

// Run level and the configuration frozen for the current burst.
interface stage_ctrl_if;

	logic run;
	logic [7:0] addr_step;
	logic [7:0] exp_ceil;
	logic [7:0] exp_time;

	modport seq
	(
		output run,
		output addr_step,
		output exp_ceil,
		output exp_time
	);

	modport cnt
	(
		input run,
		input addr_step,
		input exp_ceil,
		input exp_time
	);

endinterface

`default_nettype wire

//--- design/twiddle_exp_counter.sv
`timescale 1ns/1ps
`default_nettype none

module twiddle_exp_counter
(
	input logic clk,
	input logic rst_n,
	stage_ctrl_if.cnt ctrl,
	output logic [7:0] rdaddr [0:twiddle_pkg::LANES-1]
);

	import twiddle_pkg::*;

	logic [7:0] cnt;
	logic [7:0] n;
	logic cnt_wrap;
	logic n_wrap;

	assign cnt_wrap = (cnt == ctrl.exp_time - 8'd1);
	assign n_wrap = (n == ctrl.exp_ceil - 8'd1);

	// The inner counter sets how many valid cycles share one exponent index.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cnt <= 8'd0;
			n <= 8'd0;
		end
		else if (!ctrl.run)
		begin
			cnt <= 8'd0;
			n <= 8'd0;
		end
		else if (cnt_wrap)
		begin
			cnt <= 8'd0;
			if (n_wrap)
				n <= 8'd0;
			else
				n <= n + 8'd1;
		end
		else
		begin
			cnt <= cnt + 8'd1;
		end
	end

	// Lane i reads exponent step*n*i; the ROM reduces it modulo the table length.
	always_comb
	begin
		for (int i = 0; i < LANES; i++)
			rdaddr[i] = ctrl.addr_step * n * 8'(i);
	end

	a_n_below_ceil: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl.run |-> (n < ctrl.exp_ceil));

endmodule

`default_nettype wire

//--- design/twiddle_pfa.sv
`timescale 1ns/1ps
`default_nettype none

module twiddle_pfa
#(
	parameter int w_data = twiddle_pkg::W_DATA
)
(
	input logic clk,
	input logic rst_n,
	input twiddle_pkg::radix_t factor,
	input logic [7:0] tw_rom_addr_step,
	input logic [7:0] tw_rom_exp_ceil,
	input logic [7:0] tw_rom_exp_time,
	input logic in_val,
	input logic signed [w_data-1:0] din_real [0:twiddle_pkg::LANES-1],
	input logic signed [w_data-1:0] din_imag [0:twiddle_pkg::LANES-1],
	output logic out_val,
	output logic signed [w_data-1:0] dout_real [0:twiddle_pkg::LANES-1],
	output logic signed [w_data-1:0] dout_imag [0:twiddle_pkg::LANES-1]
);

	import twiddle_pkg::*;

	stage_ctrl_if ctrl ();

	radix_t radix;
	logic [1:0] valid_r;
	logic [7:0] rdaddr [0:LANES-1];
	logic signed [W_TW-1:0] tw_real [0:LANES-1];
	logic signed [W_TW-1:0] tw_imag [0:LANES-1];

	burst_seq_fsm u_seq
	(
		.clk (clk),
		.rst_n (rst_n),
		.in_val (in_val),
		.factor (factor),
		.addr_step (tw_rom_addr_step),
		.exp_ceil (tw_rom_exp_ceil),
		.exp_time (tw_rom_exp_time),
		.radix (radix),
		.ctrl (ctrl.seq)
	);

	twiddle_exp_counter u_cnt
	(
		.clk (clk),
		.rst_n (rst_n),
		.ctrl (ctrl.cnt),
		.rdaddr (rdaddr)
	);

	// Bit 0 marks data meeting its twiddle, bit 1 marks the registered product.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			valid_r <= 2'b00;
		else
			valid_r <= {valid_r[0], in_val};
	end

	assign out_val = valid_r[1];

	for (genvar i = 0; i < LANES; i++)
	begin : g_lane
		twiddle_rom #(.lane(i)) u_rom
		(
			.clk (clk),
			.radix (radix),
			.rdaddr (rdaddr[i]),
			.tw_real (tw_real[i]),
			.tw_imag (tw_imag[i])
		);

		cmul_lane #(.w_data(w_data)) u_mul
		(
			.clk (clk),
			.rst_n (rst_n),
			.val_d (valid_r[0]),
			.din_real (din_real[i]),
			.din_imag (din_imag[i]),
			.tw_real (tw_real[i]),
			.tw_imag (tw_imag[i]),
			.dout_real (dout_real[i]),
			.dout_imag (dout_imag[i])
		);
	end

endmodule

`default_nettype wire

//--- design/twiddle_pkg.sv
`default_nettype none

package twiddle_pkg;

	localparam int W_DATA = 30;
	localparam int W_TW = 18;
	localparam int FRAC = 16;
	localparam int W_PROD = 49;
	localparam int LANES = 5;

	localparam real TWO_PI = 6.283185307179586;

	typedef enum logic [1:0]
	{
		R_16,
		R_32,
		R_64,
		R_128
	} radix_t;

	// Each radix code doubles the table length.
	function automatic int tw_len(radix_t radix);
		return 16 << radix;
	endfunction

	// Real part of entry a in a table of length len.
	function automatic logic signed [W_TW-1:0] tw_cos(int a, int len);
		real phase;
		phase = TWO_PI * (a % len) / len;
		return W_TW'(int'($cos(phase) * 2.0 ** FRAC));
	endfunction

	function automatic logic signed [W_TW-1:0] tw_sin_neg(int a, int len);
		real phase;
		phase = TWO_PI * (a % len) / len;
		return W_TW'(int'(-$sin(phase) * 2.0 ** FRAC));
	endfunction

endpackage

`default_nettype wire

//--- design/twiddle_rom.sv
`timescale 1ns/1ps
`default_nettype none

module twiddle_rom
#(
	parameter int lane = 0
)
(
	input logic clk,
	input twiddle_pkg::radix_t radix,
	input logic [7:0] rdaddr,
	output logic signed [twiddle_pkg::W_TW-1:0] tw_real,
	output logic signed [twiddle_pkg::W_TW-1:0] tw_imag
);

	import twiddle_pkg::*;

	// The four tables sit back to back; the table of length L starts at L-16.
	localparam int ROM_DEPTH = 2 * tw_len(R_128) - 16;

	logic signed [W_TW-1:0] rom_re [0:ROM_DEPTH-1];
	logic signed [W_TW-1:0] rom_im [0:ROM_DEPTH-1];

	logic [7:0] base;
	logic [7:0] mask;
	logic [7:0] idx;

	initial
	begin
		int len;
		for (int r = 0; r < 4; r++)
		begin
			len = tw_len(radix_t'(r));
			for (int a = 0; a < len; a++)
			begin
				rom_re[len - 16 + a] = tw_cos(a, len);
				rom_im[len - 16 + a] = tw_sin_neg(a, len);
			end
		end
	end

	// Table lengths are powers of two, so masking gives the address modulo L.
	always_comb
	begin
		base = 8'(tw_len(radix) - 16);
		mask = 8'(tw_len(radix) - 1);
		idx = base + (rdaddr & mask);
	end

	always_ff @(posedge clk)
	begin
		tw_real <= rom_re[idx];
		tw_imag <= rom_im[idx];
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+test
design/twiddle_pkg.sv
design/stage_ctrl_if.sv
design/burst_seq_fsm.sv
design/twiddle_exp_counter.sv
design/twiddle_rom.sv
design/cmul_lane.sv
design/twiddle_pfa.sv
test/twiddle_tb.sv

//--- test/twiddle_ref.svh
`ifndef TWIDDLE_REF_SVH
`define TWIDDLE_REF_SVH

	localparam real PI = 3.141592653589793;

	logic [31:0] lfsr_state = 32'h6ebcd3f2;

	// Taps 32, 22, 2 and 1 give a maximal-length sequence.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken, newest bit in the LSB.
	function automatic logic [31:0] rand_bits(input int nbits);
		logic [31:0] v;
		v = '0;
		for (int b = 0; b < nbits; b++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic int table_len(input int code);
		return 16 << code;
	endfunction

	// Halves round away from zero.
	function automatic int round_nearest(input real x);
		if (x >= 0.0)
			return $rtoi(x + 0.5);
		else
			return -$rtoi(-x + 0.5);
	endfunction

	function automatic int twiddle_re(input int a, input int len);
		real phase;
		phase = 2.0 * PI * (a % len) / len;
		return round_nearest($cos(phase) * 65536.0);
	endfunction

	function automatic int twiddle_im(input int a, input int len);
		real phase;
		phase = 2.0 * PI * (a % len) / len;
		return round_nearest(-$sin(phase) * 65536.0);
	endfunction

	// Expected lane output for data d and twiddle W^a, returned as {re, im}.
	function automatic logic [2*W-1:0] lane_product(
		input logic signed [W-1:0] dre,
		input logic signed [W-1:0] dim,
		input int a,
		input int len
	);
		longint wr;
		longint wi;
		logic [63:0] pr;
		logic [63:0] pi_part;
		wr = twiddle_re(a, len);
		wi = twiddle_im(a, len);
		pr = longint'(dre) * wr - longint'(dim) * wi;
		pi_part = longint'(dre) * wi + longint'(dim) * wr;
		return {pr[W+15:16], pi_part[W+15:16]};
	endfunction

`endif

//--- test/twiddle_tb.sv
`timescale 1ns/1ps
`default_nettype none

module twiddle_tb;

	localparam int W = twiddle_pkg::W_DATA;
	localparam int LANES = twiddle_pkg::LANES;
	localparam int HALF_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int RESET_CYCLES = 4;
	localparam int RADIX_LEN = 24;
	localparam int MIX_LEN = 30;
	localparam int HOLD_LEN = 20;
	localparam int B2B_LEN = 12;
	localparam int VALID_CYCLES = 4 * RADIX_LEN + 5 * MIX_LEN + 4 * HOLD_LEN + 4 * B2B_LEN;
	localparam int TOTAL_CYCLES = RESET_CYCLES + 3 + 4 * (RADIX_LEN + 3) + 5 * (MIX_LEN + 2)
		+ 4 * (HOLD_LEN + 1) + 4 * (B2B_LEN + 1) + 4;
	localparam int TIMEOUT_CYCLES = 2 * TOTAL_CYCLES + 100;

	typedef struct packed
	{
		logic val;
		logic [LANES-1:0][W-1:0] re;
		logic [LANES-1:0][W-1:0] im;
	} expect_t;

	logic clk;
	logic rst_n;
	twiddle_pkg::radix_t factor;
	logic [7:0] addr_step;
	logic [7:0] exp_ceil;
	logic [7:0] exp_time;
	logic in_val;
	logic signed [W-1:0] din_real [0:LANES-1];
	logic signed [W-1:0] din_imag [0:LANES-1];
	logic out_val;
	logic signed [W-1:0] dout_real [0:LANES-1];
	logic signed [W-1:0] dout_imag [0:LANES-1];

	expect_t exp_q [$];
	int held_code;
	int held_step;
	int held_ceil;
	int held_time;
	int model_cnt;
	int model_n;
	int checks_done = 0;
	int cycle_count = 0;

	`include "twiddle_ref.svh"

	twiddle_pfa #(.w_data(W)) dut0
	(
		.clk (clk),
		.rst_n (rst_n),
		.factor (factor),
		.tw_rom_addr_step (addr_step),
		.tw_rom_exp_ceil (exp_ceil),
		.tw_rom_exp_time (exp_time),
		.in_val (in_val),
		.din_real (din_real),
		.din_imag (din_imag),
		.out_val (out_val),
		.dout_real (dout_real),
		.dout_imag (dout_imag)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#HALF_PERIOD clk = ~clk;
	end

	task automatic check_value(input string name, input logic [W-1:0] got,
		input logic [W-1:0] expv);
		assert (got === expv)
		else
		begin
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, expv);
			$display("TESTS FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// Mirrors the held burst configuration and the exponent schedule.
	always @(posedge clk)
	begin : reference_model
		expect_t e;
		logic [2*W-1:0] prod;
		int expo;
		e = '0;
		if (!rst_n)
		begin
			held_code = 0;
			held_step = 0;
			held_ceil = 1;
			held_time = 1;
			model_cnt = 0;
			model_n = 0;
		end
		else if (!in_val)
		begin
			held_code = factor;
			held_step = addr_step;
			held_ceil = exp_ceil;
			held_time = exp_time;
			model_cnt = 0;
			model_n = 0;
		end
		else
		begin
			e.val = 1'b1;
			for (int i = 0; i < LANES; i++)
			begin
				expo = (held_step * model_n * i) % 256;
				prod = lane_product(din_real[i], din_imag[i], expo, table_len(held_code));
				e.re[i] = prod[2*W-1:W];
				e.im[i] = prod[W-1:0];
			end
			if (model_cnt == held_time - 1)
			begin
				model_cnt = 0;
				model_n = (model_n == held_ceil - 1) ? 0 : model_n + 1;
			end
			else
				model_cnt = model_cnt + 1;
		end
		exp_q.push_back(e);
	end

	// Outputs settle after the rising edge, so they are read on the falling one.
	always @(negedge clk)
	begin : compare_outputs
		expect_t e;
		if (exp_q.size() == 2)
		begin
			e = exp_q.pop_front();
			check_value("out_val", out_val, e.val);
			for (int i = 0; i < LANES; i++)
			begin
				check_value($sformatf("dout_real[%0d]", i), dout_real[i], e.re[i]);
				check_value($sformatf("dout_imag[%0d]", i), dout_imag[i], e.im[i]);
			end
			if (e.val)
				checks_done++;
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$fatal(1, "Timeout");
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
		for (int i = 0; i < LANES; i++)
		begin
			din_real[i] = rand_bits(W);
			din_imag[i] = rand_bits(W);
		end
	endtask

	task automatic set_cfg(input int code, input int step, input int ceil_v, input int time_v);
		factor = twiddle_pkg::radix_t'(code % 4);
		addr_step = 8'(step);
		exp_ceil = 8'(ceil_v);
		exp_time = 8'(time_v);
	endtask

	task automatic idle_cycles(input int count);
		repeat (count)
		begin
			next_cycle();
			in_val = 1'b0;
		end
	endtask

	// One idle cycle, then len valid cycles; the config may change at change_at.
	task automatic run_burst(input bit new_cfg, input int code, input int step,
		input int ceil_v, input int time_v, input int len, input int change_at);
		next_cycle();
		in_val = 1'b0;
		if (new_cfg)
			set_cfg(code, step, ceil_v, time_v);
		for (int k = 0; k < len; k++)
		begin
			next_cycle();
			in_val = 1'b1;
			if (k == change_at)
				set_cfg(rand_bits(2), rand_bits(8), 1 + rand_bits(3), 1 + rand_bits(2));
		end
	endtask

	initial
	begin
		rst_n = 1'b0;
		in_val = 1'b0;
		set_cfg(0, 0, 1, 1);
		for (int i = 0; i < LANES; i++)
		begin
			din_real[i] = '0;
			din_imag[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		idle_cycles(3);

		for (int r = 0; r < 4; r++)
		begin
			run_burst(1, r, rand_bits(8), 1 + rand_bits(3), 1 + rand_bits(2), RADIX_LEN, -1);
			idle_cycles(2);
		end

		// Periods and ceilings of one sit at the edges of the counter rule.
		run_burst(1, 3, rand_bits(8) | 1, 1, 1, MIX_LEN, -1);
		idle_cycles(1);
		run_burst(1, 2, rand_bits(8) | 1, 7, 1, MIX_LEN, -1);
		idle_cycles(1);
		run_burst(1, 1, rand_bits(8) | 1, 1, 3, MIX_LEN, -1);
		idle_cycles(1);
		run_burst(1, 3, rand_bits(8) | 1, 5, 2, MIX_LEN, -1);
		idle_cycles(1);
		run_burst(1, 0, rand_bits(8) | 1, 3, 4, MIX_LEN, -1);
		idle_cycles(1);

		// The second burst picks up what was changed inside the first.
		for (int k = 0; k < 2; k++)
		begin
			run_burst(1, rand_bits(2), rand_bits(8) | 1, 2, 2, HOLD_LEN, 6);
			run_burst(0, 0, 0, 0, 0, HOLD_LEN, -1);
		end

		for (int k = 0; k < 4; k++)
			run_burst(1, k, rand_bits(8) | 1, 200, 1, B2B_LEN, -1);

		idle_cycles(4);
		if (checks_done != VALID_CYCLES)
		begin
			$display("Only %0d of %0d valid outputs were compared", checks_done, VALID_CYCLES);
			$display("TESTS FAILED");
			$fatal(1, "Missing outputs");
		end
		else
		begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
